//--- common/bm_pkg.sv
// Word and timestamp widths are fixed at 64 bits and the header layout assumes SEQ_W <= 16
package bm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [63:0] word_t;  // Stream and FIFO data word
  typedef logic [63:0] ts_t;    // Timestamp or latency in cycles
  typedef logic [31:0] len_t;   // Payload length in words

  ////////////////////////////////////////////////////////////////////////////
  // Header layout
  ////////////////////////////////////////////////////////////////////////////

  // Sequence number sits in the low bits and the length field above it
  // All header bits outside these two fields are zero
  localparam int HDR_SEQ_LSB = 0;   // Sequence number start bit
  localparam int HDR_LEN_LSB = 16;  // Payload length start bit

  // 8 bits of sequence number give a 256 entry timestamp memory
  localparam int SEQ_W_DEFAULT = 8;

  ////////////////////////////////////////////////////////////////////////////
  // FSM encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    TX_IDLE = 2'd0,  // Waiting for run
    TX_HDR  = 2'd1,  // Header word on the stream
    TX_PAY  = 2'd2   // Payload words from the read FIFO
  } tx_state_e;

  typedef enum logic {
    RX_HDR = 1'b0,  // Next beat is a header
    RX_PAY = 1'b1   // Next beat is payload
  } rx_state_e;

endpackage

//--- latency/bm_latency_mem.sv
// Read is registered with one cycle latency; same-address read and write returns old data
`timescale 1ns/1ps

module bm_latency_mem import bm_pkg::*; #(
  parameter int SEQ_W = SEQ_W_DEFAULT  // Address width
) (
  input  logic             clk,
  input  logic             wr_en_i,    // Header send time
  input  logic [SEQ_W-1:0] wr_addr_i,
  input  ts_t              wr_data_i,
  input  logic             rd_en_i,    // Echo lookup
  input  logic [SEQ_W-1:0] rd_addr_i,
  output ts_t              rd_data_o
);

  localparam int DEPTH = 1 << SEQ_W;  // One entry per sequence number

  ts_t mem_q [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];  // Pre-write contents on collision
    end
  end

  a_wr_addr_known : assert property (@(posedge clk)
    wr_en_i |-> !$isunknown(wr_addr_i));

  a_rd_addr_known : assert property (@(posedge clk)
    rd_en_i |-> !$isunknown(rd_addr_i));

endmodule

//--- verilog/bm_start_ctrl.sv
// Start is edge detected so a held-high calc_start_i restarts only once; finish waits for tx idle
`timescale 1ns/1ps

module bm_start_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic calc_start_i,   // Rising edge begins a run
  input  logic calc_finish_i,  // Stop at next packet boundary
  input  logic tx_idle_i,      // TX FSM idle
  output logic init_o,         // One-cycle restart pulse
  output logic run_o,          // Transmit enable level
  output logic done_o          // Finished and idle
);

  logic start_q;     // Registered start input
  logic start_qq;    // Previous start sample
  logic start_edge;  // Rising edge seen
  logic init_d1;     // Init delayed one cycle
  logic finish_q;    // Finish requested

  assign start_edge = start_q & ~start_qq;

  // Edge detect and init pulse
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_q  <= 1'b0;
      start_qq <= 1'b0;
      init_o   <= 1'b0;
      init_d1  <= 1'b0;
    end else begin
      start_q  <= calc_start_i;
      start_qq <= start_q;
      init_o   <= start_edge;  // One cycle after the edge
      init_d1  <= init_o;
    end
  end

  // Run rises two cycles after init
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_o <= 1'b0;
    end else if (start_edge || calc_finish_i) begin
      run_o <= 1'b0;  // Hold off during restart
    end else if (init_d1 && !finish_q) begin
      run_o <= 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      finish_q <= 1'b0;
    end else if (start_edge) begin
      finish_q <= 1'b0;  // New run clears finish
    end else if (calc_finish_i) begin
      finish_q <= 1'b1;
    end
  end

  assign done_o = finish_q & tx_idle_i;  // Current packet has drained

  a_init_single : assert property (@(posedge clk) disable iff (!rst_n)
    init_o |=> !init_o);

endmodule

//--- tx/bm_tx_engine.sv
// FIFO must be FWFT; init restarts the counters but lets a packet in flight complete
`timescale 1ns/1ps

module bm_tx_engine import bm_pkg::*; #(
  parameter int SEQ_W = SEQ_W_DEFAULT  // Sequence number width
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             init_i,          // Restart counters
  input  logic             run_i,           // Allow new packets
  input  len_t             packet_len_i,    // Payload words per packet
  input  word_t            fifo_rd_data_i,  // FWFT head word
  input  logic             fifo_empty_i,
  input  logic             tx_ready_i,
  output logic             fifo_rd_en_o,    // Pop on payload transfer
  output logic             tx_valid_o,
  output word_t            tx_data_o,
  output logic             tx_last_o,
  output logic             tx_idle_o,
  output ts_t              ts_now_o,        // Current cycle count
  output logic             ts_wr_en_o,      // Header transferred
  output logic [SEQ_W-1:0] ts_wr_addr_o,
  output ts_t              ts_wr_data_o
);

  tx_state_e        state_q;
  ts_t              ts_cnt_q;    // Free-running timestamp
  logic [SEQ_W-1:0] seq_q;       // Sequence number of next header
  len_t             len_q;       // Length latched at packet start
  len_t             beat_cnt_q;  // Payload words still to send
  word_t            hdr_word;
  logic             hdr_xfer;    // Header accepted downstream
  logic             pay_xfer;    // Payload word accepted downstream

  ////////////////////////////////////////////////////////////////////////////
  // Timestamp and sequence counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ts_cnt_q <= '0;
    end else if (init_i) begin
      ts_cnt_q <= '0;
    end else begin
      ts_cnt_q <= ts_cnt_q + 1'b1;  // Counts every cycle
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seq_q <= '0;
    end else if (init_i) begin
      seq_q <= '0;
    end else if (hdr_xfer) begin
      seq_q <= seq_q + 1'b1;  // Wraps at 2**SEQ_W
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Packet FSM
  ////////////////////////////////////////////////////////////////////////////

  assign hdr_xfer = (state_q == TX_HDR) && tx_ready_i;
  assign pay_xfer = (state_q == TX_PAY) && !fifo_empty_i && tx_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= TX_IDLE;
      beat_cnt_q <= '0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (run_i) begin
            state_q <= TX_HDR;  // Header next cycle
          end
        end
        TX_HDR: begin
          if (hdr_xfer) begin
            beat_cnt_q <= len_q;
            state_q    <= (len_q == '0) ? TX_IDLE : TX_PAY;  // Zero length is header only
          end
        end
        TX_PAY: begin
          if (pay_xfer) begin
            beat_cnt_q <= beat_cnt_q - 1'b1;
            if (beat_cnt_q == len_t'(1)) begin
              state_q <= TX_IDLE;
            end
          end
        end
        default: state_q <= TX_IDLE;
      endcase
    end
  end

  // Length sampled once per packet
  always_ff @(posedge clk) begin
    if (state_q == TX_IDLE && run_i) begin
      len_q <= packet_len_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stream outputs
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    hdr_word                                 = '0;
    hdr_word[HDR_SEQ_LSB +: SEQ_W]           = seq_q;
    hdr_word[HDR_LEN_LSB +: $bits(len_t)]    = len_q;
  end

  assign tx_valid_o   = (state_q == TX_HDR) || ((state_q == TX_PAY) && !fifo_empty_i);
  assign tx_data_o    = (state_q == TX_PAY) ? fifo_rd_data_i : hdr_word;
  assign tx_last_o    = (state_q == TX_PAY) ? (beat_cnt_q == len_t'(1)) : (len_q == '0);
  assign fifo_rd_en_o = pay_xfer;
  assign tx_idle_o    = (state_q == TX_IDLE);

  // Send time recorded as the header leaves
  assign ts_now_o     = ts_cnt_q;
  assign ts_wr_en_o   = hdr_xfer;
  assign ts_wr_addr_o = seq_q;
  assign ts_wr_data_o = ts_cnt_q;

  a_stall_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (tx_valid_o && !tx_ready_i && !init_i) |=> ($stable(tx_data_o) && $stable(tx_last_o)));

endmodule

//--- rx/bm_rx_engine.sv
// No back-pressure on the echo stream; latency is valid only if the echoed seq was sent this run
`timescale 1ns/1ps

module bm_rx_engine import bm_pkg::*; #(
  parameter int SEQ_W = SEQ_W_DEFAULT  // Sequence number width
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             init_i,          // Resync to header
  input  logic             rx_valid_i,
  input  word_t            rx_data_i,
  input  logic             rx_last_i,
  input  ts_t              ts_now_i,        // Arrival time source
  input  ts_t              ts_rd_data_i,    // Stored send time
  output logic             ts_rd_en_o,
  output logic [SEQ_W-1:0] ts_rd_addr_o,
  output logic             fifo_wr_en_o,
  output word_t            fifo_wr_data_o,
  output logic             lat_valid_o,
  output logic [SEQ_W-1:0] lat_seq_o,
  output ts_t              lat_value_o
);

  rx_state_e        state_q;
  logic             hdr_beat;   // Header accepted this cycle
  logic             pay_beat;   // Payload accepted this cycle
  logic             s1_valid_q;
  logic [SEQ_W-1:0] s1_seq_q;   // Seq while memory read is in flight
  ts_t              s1_ts_q;    // Arrival time of header

  assign hdr_beat = rx_valid_i && (state_q == RX_HDR);
  assign pay_beat = rx_valid_i && (state_q == RX_PAY);

  ////////////////////////////////////////////////////////////////////////////
  // Beat framing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RX_HDR;
    end else if (init_i) begin
      state_q <= RX_HDR;
    end else if (rx_valid_i) begin
      state_q <= rx_last_i ? RX_HDR : RX_PAY;  // Last beat ends the packet
    end
  end

  // Payload forwarded one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fifo_wr_en_o <= 1'b0;
    end else begin
      fifo_wr_en_o <= pay_beat;
    end
  end

  always_ff @(posedge clk) begin
    fifo_wr_data_o <= rx_data_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Latency pipeline
  ////////////////////////////////////////////////////////////////////////////

  // Fetch the send time for the echoed sequence number
  assign ts_rd_en_o   = hdr_beat;
  assign ts_rd_addr_o = rx_data_i[HDR_SEQ_LSB +: SEQ_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q  <= 1'b0;
      lat_valid_o <= 1'b0;
    end else begin
      s1_valid_q  <= hdr_beat;    // Memory data lands here
      lat_valid_o <= s1_valid_q;  // Two cycles after header
    end
  end

  always_ff @(posedge clk) begin
    if (hdr_beat) begin
      s1_seq_q <= ts_rd_addr_o;
      s1_ts_q  <= ts_now_i;
    end
    if (s1_valid_q) begin
      lat_seq_o   <= s1_seq_q;
      lat_value_o <= s1_ts_q - ts_rd_data_i;  // Round trip in cycles
    end
  end

  a_lat_valid_known : assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(lat_valid_o));

endmodule

//--- verilog/bm_endpoint.sv
// Receive stream has no ready and must be consumed every valid cycle; read FIFO must be FWFT
`timescale 1ns/1ps

module bm_endpoint import bm_pkg::*; #(
  parameter int SEQ_W = SEQ_W_DEFAULT  // Sequence number width
) (
  input  logic             clk,
  input  logic             rst_n,
  // Run control
  input  logic             calc_start_i,
  input  logic             calc_finish_i,
  input  len_t             packet_len_i,    // Payload words per packet
  // Output stream
  input  logic             tx_ready_i,
  output logic             tx_valid_o,
  output word_t            tx_data_o,
  output logic             tx_last_o,
  // Read FIFO
  input  word_t            fifo_rd_data_i,
  input  logic             fifo_empty_i,
  output logic             fifo_rd_en_o,
  // Receive stream
  input  logic             rx_valid_i,
  input  word_t            rx_data_i,
  input  logic             rx_last_i,
  // Write FIFO
  output logic             fifo_wr_en_o,
  output word_t            fifo_wr_data_o,
  // Latency report
  output logic             lat_valid_o,
  output logic [SEQ_W-1:0] lat_seq_o,
  output ts_t              lat_value_o,
  output logic             done_o
);

  logic             init;          // One-cycle restart
  logic             run;           // Transmit enable
  logic             tx_idle;       // TX FSM at packet boundary
  ts_t              ts_now;        // Free-running cycle count
  logic             ts_wr_en;      // Header sent
  logic [SEQ_W-1:0] ts_wr_addr;
  ts_t              ts_wr_data;
  logic             ts_rd_en;      // Echoed header seen
  logic [SEQ_W-1:0] ts_rd_addr;
  ts_t              ts_rd_data;

  ////////////////////////////////////////////////////////////////////////////
  // Start and finish sequencing
  ////////////////////////////////////////////////////////////////////////////

  bm_start_ctrl i_start_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .calc_start_i  (calc_start_i),
    .calc_finish_i (calc_finish_i),
    .tx_idle_i     (tx_idle),
    .init_o        (init),
    .run_o         (run),
    .done_o        (done_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Transmit path
  ////////////////////////////////////////////////////////////////////////////

  bm_tx_engine #(
    .SEQ_W (SEQ_W)
  ) i_tx_engine (
    .clk            (clk),
    .rst_n          (rst_n),
    .init_i         (init),
    .run_i          (run),
    .packet_len_i   (packet_len_i),
    .fifo_rd_data_i (fifo_rd_data_i),
    .fifo_empty_i   (fifo_empty_i),
    .tx_ready_i     (tx_ready_i),
    .fifo_rd_en_o   (fifo_rd_en_o),
    .tx_valid_o     (tx_valid_o),
    .tx_data_o      (tx_data_o),
    .tx_last_o      (tx_last_o),
    .tx_idle_o      (tx_idle),
    .ts_now_o       (ts_now),
    .ts_wr_en_o     (ts_wr_en),
    .ts_wr_addr_o   (ts_wr_addr),
    .ts_wr_data_o   (ts_wr_data)
  );

  // Send times indexed by sequence number
  bm_latency_mem #(
    .SEQ_W (SEQ_W)
  ) i_latency_mem (
    .clk       (clk),
    .wr_en_i   (ts_wr_en),
    .wr_addr_i (ts_wr_addr),
    .wr_data_i (ts_wr_data),
    .rd_en_i   (ts_rd_en),
    .rd_addr_i (ts_rd_addr),
    .rd_data_o (ts_rd_data)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Receive path
  ////////////////////////////////////////////////////////////////////////////

  bm_rx_engine #(
    .SEQ_W (SEQ_W)
  ) i_rx_engine (
    .clk            (clk),
    .rst_n          (rst_n),
    .init_i         (init),
    .rx_valid_i     (rx_valid_i),
    .rx_data_i      (rx_data_i),
    .rx_last_i      (rx_last_i),
    .ts_now_i       (ts_now),
    .ts_rd_data_i   (ts_rd_data),
    .ts_rd_en_o     (ts_rd_en),
    .ts_rd_addr_o   (ts_rd_addr),
    .fifo_wr_en_o   (fifo_wr_en_o),
    .fifo_wr_data_o (fifo_wr_data_o),
    .lat_valid_o    (lat_valid_o),
    .lat_seq_o      (lat_seq_o),
    .lat_value_o    (lat_value_o)
  );

endmodule

//--- dv/bm_endpoint_tests.svh
// Tests assume the DUT is idle and drained on entry; each run restarts seq numbers at 0

task automatic fill_fifo(input int n);
  word_t w;
  repeat (n) begin
    w = {$random(seed), $random(seed)};
    fifo_q.push_back(w);
    exp_pay.push_back(w);  // Same order as the FIFO
  end
endtask

task automatic start_run(input int len);
  packet_len_i = len;
  calc_start_i = 1'b1;
  exp_seq      = '0;
  tx_in_hdr    = 1'b1;
  hdr_count    = 0;
  repeat (3) step();
  calc_start_i = 1'b0;
endtask

task automatic wait_headers(input int n);
  int t = 0;
  while (hdr_count < n) begin
    step();
    if (++t > TIMEOUT) abort_run("Timed out waiting for packet headers");
  end
endtask

task automatic stop_run();
  int t = 0;
  calc_finish_i = 1'b1;
  step();
  calc_finish_i = 1'b0;
  while (!done_o) begin
    step();
    if (++t > TIMEOUT) abort_run("done_o never rose after finish");
  end
  check_value("packet complete at done", 0, pay_left);  // Last beat already out
  t = 0;
  while (loop_q.size() != 0 || exp_lat_seq.size() != 0 || exp_wr.size() != 0) begin
    step();
    if (++t > TIMEOUT) abort_run("Echo traffic did not drain");
  end
endtask

task automatic quiet_after_reset();
  cur_test = "quiet_after_reset";
  repeat (20) begin
    step();
    check_value("outputs idle", 0,
                {tx_valid_o, fifo_rd_en_o, fifo_wr_en_o, lat_valid_o, done_o});
  end
  end_test();
endtask

task automatic packet_format();
  cur_test = "packet_format";
  loop_en  = 1'b1;
  fill_fifo(24);
  start_run(3);
  wait_headers(4);
  stop_run();
  start_run(0);  // Header-only packets
  wait_headers(3);
  stop_run();
  end_test();
endtask

task automatic random_backpressure();
  cur_test  = "random_backpressure";
  fill_fifo(48);
  rand_mode = 1'b1;
  start_run(4);
  wait_headers(6);
  stop_run();
  rand_mode  = 1'b0;
  tx_ready_i = 1'b1;
  end_test();
endtask

task automatic echo_latency();
  int lat_before;
  cur_test   = "echo_latency";
  lat_before = lat_count;
  fill_fifo(24);
  start_run(2);
  wait_headers(5);
  stop_run();
  check_value("latency reports", hdr_count, lat_count - lat_before);
  end_test();
endtask

task automatic finish_and_restart();
  int t = 0;
  int hdr_seen;
  cur_test = "finish_and_restart";
  fill_fifo(40);
  start_run(6);
  while (tx_in_hdr || pay_left != 4) begin  // Two payload beats out
    step();
    if (++t > TIMEOUT) abort_run("Packet never reached mid-payload");
  end
  stop_run();
  hdr_seen = hdr_count;
  repeat (20) step();
  check_value("headers after finish", hdr_seen, hdr_count);
  check_value("done held", 1, done_o);
  start_run(6);
  step();
  check_value("done cleared", 0, done_o);
  wait_headers(1);  // Monitor expects seq 0 again
  stop_run();
  end_test();
endtask

//--- dv/bm_endpoint_tb.sv
// Loopback echoes every sent beat when enabled; seq width must match SEQ_W_DEFAULT of the DUT
`timescale 1ns/1ps

module bm_endpoint_tb import bm_pkg::*;;

  localparam int SEQ_W   = SEQ_W_DEFAULT;
  localparam int TIMEOUT = 2000;  // Cycles per wait loop

  logic             clk;
  logic             rst_n;
  logic             calc_start_i;
  logic             calc_finish_i;
  len_t             packet_len_i;
  logic             tx_ready_i;
  logic             tx_valid_o;
  word_t            tx_data_o;
  logic             tx_last_o;
  word_t            fifo_rd_data_i;
  logic             fifo_empty_i;
  logic             fifo_rd_en_o;
  logic             rx_valid_i;
  word_t            rx_data_i;
  logic             rx_last_i;
  logic             fifo_wr_en_o;
  word_t            fifo_wr_data_o;
  logic             lat_valid_o;
  logic [SEQ_W-1:0] lat_seq_o;
  ts_t              lat_value_o;
  logic             done_o;

  integer           seed = 32'h98d1;
  string            cur_test;
  int               test_errs, errors, passed, failed;
  longint           cyc;                // TB cycle count
  word_t            fifo_q[$];          // Read FIFO contents
  word_t            exp_pay[$];         // Expected payload order
  word_t            loop_q[$];          // Echo beats (data)
  logic             loop_last_q[$];     // Echo beats (last)
  word_t            exp_wr[$];          // Expected write FIFO words
  logic [SEQ_W-1:0] exp_lat_seq[$];
  ts_t              exp_lat_val[$];
  ts_t              tx_hdr_time [1<<SEQ_W];
  logic [SEQ_W-1:0] exp_seq;
  logic             tx_in_hdr, rx_in_hdr, pop_req, loop_en, rand_mode, hold_empty;
  int               pay_left, hdr_count, lat_count, gap_cnt;
  word_t            exp_hdr;

  bm_endpoint #(.SEQ_W(SEQ_W)) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking and flow helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("Fail %s (%s): expected %h, actual %h", cur_test, what, exp, act);
      test_errs++;
      errors++;
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic step();
    @(posedge clk);
    #1;  // Past all DUT updates
  endtask

  task automatic end_test();
    $display("%s finished with %0d errors", cur_test, test_errs);
    if (test_errs == 0) passed++;
    else failed++;
    test_errs = 0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors on the stable values at each rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    pop_req = fifo_rd_en_o;  // FIFO pops what the DUT reads
    if (rst_n) begin
      check_value("read enable", tx_valid_o && tx_ready_i && !tx_in_hdr, fifo_rd_en_o);
      if (tx_valid_o && !tx_in_hdr && fifo_empty_i)
        check_value("payload valid on empty FIFO", 0, 1);
    end
    if (rst_n && tx_valid_o && tx_ready_i) begin
      if (tx_in_hdr) begin
        exp_hdr = '0;
        exp_hdr[HDR_SEQ_LSB +: SEQ_W] = exp_seq;
        exp_hdr[HDR_LEN_LSB +: $bits(len_t)] = packet_len_i;
        check_value("header", exp_hdr, tx_data_o);
        check_value("header last", packet_len_i == 0, tx_last_o);
        tx_hdr_time[exp_seq] = cyc;  // Send time
        exp_seq++;
        hdr_count++;
        pay_left  = packet_len_i;
        tx_in_hdr = (packet_len_i == 0);
      end else begin
        if (exp_pay.size() == 0) check_value("payload beyond FIFO", 0, 1);
        else check_value("payload", exp_pay.pop_front(), tx_data_o);
        pay_left--;
        check_value("payload last", pay_left == 0, tx_last_o);
        tx_in_hdr = (pay_left == 0);
      end
      if (loop_en) begin
        loop_q.push_back(tx_data_o);
        loop_last_q.push_back(tx_last_o);
      end
    end
    if (rst_n && rx_valid_i) begin
      if (rx_in_hdr) begin
        exp_lat_seq.push_back(rx_data_i[HDR_SEQ_LSB +: SEQ_W]);
        exp_lat_val.push_back(cyc - tx_hdr_time[rx_data_i[HDR_SEQ_LSB +: SEQ_W]]);
      end else begin
        exp_wr.push_back(rx_data_i);
      end
      rx_in_hdr = rx_last_i;
    end
    if (fifo_wr_en_o) begin
      if (exp_wr.size() == 0) check_value("unexpected write", 0, 1);
      else check_value("write data", exp_wr.pop_front(), fifo_wr_data_o);
    end
    if (lat_valid_o) begin
      lat_count++;
      if (exp_lat_seq.size() == 0) begin
        check_value("unexpected latency", 0, 1);
      end else begin
        check_value("latency seq", exp_lat_seq.pop_front(), lat_seq_o);
        check_value("latency value", exp_lat_val.pop_front(), lat_value_o);
      end
    end
    cyc++;
  end

  // FIFO, ready and loopback models
  always @(posedge clk) begin
    #1;
    if (pop_req && fifo_q.size() != 0) void'(fifo_q.pop_front());
    if (rand_mode) begin
      tx_ready_i = $random(seed) & 1;
      if (($random(seed) & 7) == 0) hold_empty = ~hold_empty;  // Empty spells
    end else begin
      hold_empty = 1'b0;
    end
    fifo_empty_i   = hold_empty || (fifo_q.size() == 0);
    fifo_rd_data_i = (fifo_q.size() != 0) ? fifo_q[0] : '0;
    rx_valid_i     = 1'b0;
    if (gap_cnt > 0) begin
      gap_cnt--;
    end else if (loop_q.size() != 0) begin
      rx_valid_i = 1'b1;
      rx_data_i  = loop_q.pop_front();
      rx_last_i  = loop_last_q.pop_front();
      if (rx_last_i) gap_cnt = $unsigned($random(seed)) % 5;  // Gap between echoes
    end
  end

  `include "bm_endpoint_tests.svh"

  initial begin
    #4_000_000;
    abort_run("Simulation exceeded its overall time limit");
  end

  initial begin
    rst_n          = 1'b0;
    calc_start_i   = 1'b0;
    calc_finish_i  = 1'b0;
    packet_len_i   = '0;
    tx_ready_i     = 1'b1;
    fifo_rd_data_i = '0;
    fifo_empty_i   = 1'b1;
    rx_valid_i     = 1'b0;
    rx_data_i      = '0;
    rx_last_i      = 1'b0;
    cyc            = 0;
    test_errs      = 0;
    errors         = 0;
    passed         = 0;
    failed         = 0;
    exp_seq        = '0;
    tx_in_hdr      = 1'b1;
    rx_in_hdr      = 1'b1;
    pop_req        = 1'b0;
    loop_en        = 1'b0;
    rand_mode      = 1'b0;
    hold_empty     = 1'b0;
    pay_left       = 0;
    hdr_count      = 0;
    lat_count      = 0;
    gap_cnt        = 0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    quiet_after_reset();
    packet_format();
    random_backpressure();
    echo_latency();
    finish_and_restart();
    $display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
    if (errors == 0) $display("TEST RESULT: PASS");
    else $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- bm_endpoint.f
+incdir+dv
common/bm_pkg.sv
latency/bm_latency_mem.sv
verilog/bm_start_ctrl.sv
tx/bm_tx_engine.sv
rx/bm_rx_engine.sv
verilog/bm_endpoint.sv
dv/bm_endpoint_tb.sv
